/* design/bridge_params.svh */
////////////////////////////////////////////////////////////
// AHB host bridge parameters
// Bus widths, FIFO byte width, frame limits and the fixed
// HPROT attribute driven on every master transfer
////////////////////////////////////////////////////////////
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// AHB-Lite address and data widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// Host FIFO byte width
`define BRIDGE_BYTE_W 8

// Longest command payload and longest response frame, in bytes
`define BRIDGE_IN_FRAME_MAX 8
`define BRIDGE_OUT_FRAME_MAX 5

// Privileged data access
`define BRIDGE_HPROT 4'b0011

`endif

/* design/ahb_pkg.sv */
////////////////////////////////////////////////////////////
// AHB-Lite types
// Transfer type and size encodings used by the master side
////////////////////////////////////////////////////////////
package ahb_pkg;

   typedef enum logic [1:0]
   {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_t;

   typedef logic [2:0] hsize_t;

   // Largest size the bridge issues
   localparam hsize_t HSIZE_WORD = 3'b010;

   // Single transfer, no burst
   localparam logic [2:0] HBURST_SINGLE = 3'b000;

endpackage

/* design/host_proto_pkg.sv */
////////////////////////////////////////////////////////////
// Host byte protocol
// Command opcodes, transfer sizes and the response header
////////////////////////////////////////////////////////////
package host_proto_pkg;

   typedef enum logic [1:0]
   {
      XFER_BYTE = 2'd0,
      XFER_HALF = 2'd1,
      XFER_WORD = 2'd2,
      XFER_RSVD = 2'd3
   } xfer_size_t;

   // Command byte bits 7:3
   typedef enum logic [4:0]
   {
      MST_READ      = 5'b00100,
      MST_READ_INC  = 5'b00101,
      MST_WRITE     = 5'b00110,
      MST_WRITE_INC = 5'b00111
   } host_op_t;

   // Response header is {RESP_TAG, HRESP, size or RESP_WR_FIELD}
   localparam logic [4:0] RESP_TAG      = 5'b00010;
   localparam logic [1:0] RESP_WR_FIELD = 2'b11;

   // Byte count of a transfer size
   function automatic logic [2:0] xfer_bytes(xfer_size_t size);
      case (size)
         XFER_BYTE: return 3'd1;
         XFER_HALF: return 3'd2;
         XFER_WORD: return 3'd4;
         default:   return 3'd0;
      endcase
   endfunction

endpackage

/* design/host_cmd_parser.sv */
////////////////////////////////////////////////////////////
// Host command parser
// Pulls bytes from the read FIFO, decodes command bytes and
// collects payload into two frame buffers for the engine
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bridge_params.svh"

module host_cmd_parser (
   input  logic                              CLK,
   input  logic                              RESETn,
   input  logic                              fifo_rdempty,
   input  logic [`BRIDGE_BYTE_W-1:0]         fifo_rddata,
   output logic                              fifo_rden,
   output logic                              cmd_valid,
   output host_proto_pkg::host_op_t          cmd_op,
   output host_proto_pkg::xfer_size_t        cmd_size,
   output logic [`BRIDGE_ADDR_W-1:0]         cmd_addr,
   output logic [`BRIDGE_DATA_W-1:0]         cmd_data,
   input  logic                              cmd_take
);
   import host_proto_pkg::*;

   localparam int FRAME_W    = `BRIDGE_IN_FRAME_MAX * `BRIDGE_BYTE_W;
   localparam int CNT_W      = $clog2(`BRIDGE_IN_FRAME_MAX + 1);
   localparam int ADDR_BYTES = `BRIDGE_ADDR_W / `BRIDGE_BYTE_W;

   logic [1:0][FRAME_W-1:0] frame;
   host_op_t                frame_op [2];
   xfer_size_t              frame_size [2];
   logic [1:0]              full;
   logic                    wr_idx;
   logic                    rd_idx;
   logic                    rd_pend;
   logic [CNT_W-1:0]        remain;

   host_op_t                byte_op;
   xfer_size_t              byte_size;
   logic [CNT_W-1:0]        byte_len;
   logic                    byte_ok;

   // One byte may still be in flight, so stop early when the other buffer is taken
   assign fifo_rden = !fifo_rdempty && !full[wr_idx] && !(rd_pend && full[!wr_idx]);

   // Decode of the byte on fifo_rddata as a command
   always_comb
   begin
      byte_op   = host_op_t'(fifo_rddata[7:3]);
      byte_size = xfer_size_t'(fifo_rddata[1:0]);
      byte_ok   = (byte_size != XFER_RSVD);
      byte_len  = '0;
      case (byte_op)
         MST_READ:      byte_len = CNT_W'(ADDR_BYTES);
         MST_READ_INC:  byte_len = '0;
         MST_WRITE:     byte_len = CNT_W'(ADDR_BYTES + xfer_bytes(byte_size));
         MST_WRITE_INC: byte_len = CNT_W'(xfer_bytes(byte_size));
         default:       byte_ok = 1'b0;
      endcase
   end

   always_ff @(posedge CLK)
   begin
      if (!RESETn)
      begin
         full    <= '0;
         wr_idx  <= 1'b0;
         rd_idx  <= 1'b0;
         rd_pend <= 1'b0;
         remain  <= '0;
      end
      else
      begin
         rd_pend <= fifo_rden;
         if (rd_pend)
         begin
            if (remain == '0)
            begin
               // Reserved codes fall through with nothing stored
               if (byte_ok && byte_len == '0)
               begin
                  full[wr_idx] <= 1'b1;
                  wr_idx       <= !wr_idx;
               end
               else if (byte_ok)
                  remain <= byte_len;
            end
            else
            begin
               remain <= remain - 1'b1;
               if (remain == CNT_W'(1))
               begin
                  full[wr_idx] <= 1'b1;
                  wr_idx       <= !wr_idx;
               end
            end
         end
         if (cmd_take)
         begin
            full[rd_idx] <= 1'b0;
            rd_idx       <= !rd_idx;
         end
      end
   end

   // Frame contents, payload shifted in most significant byte first
   always_ff @(posedge CLK)
   begin
      if (rd_pend)
      begin
         if (remain == '0)
         begin
            frame_op[wr_idx]   <= byte_op;
            frame_size[wr_idx] <= byte_size;
            frame[wr_idx]      <= '0;
         end
         else
            frame[wr_idx] <= {frame[wr_idx][FRAME_W-`BRIDGE_BYTE_W-1:0], fifo_rddata};
      end
   end

   assign cmd_valid = full[rd_idx];
   assign cmd_op    = frame_op[rd_idx];
   assign cmd_size  = frame_size[rd_idx];
   assign cmd_addr  = frame[rd_idx][`BRIDGE_ADDR_W-1:0];

   // MST_WRITE data sits above the address bytes
   assign cmd_data = (cmd_op == MST_WRITE) ? frame[rd_idx][`BRIDGE_ADDR_W +: `BRIDGE_DATA_W]
                                           : frame[rd_idx][`BRIDGE_DATA_W-1:0];

   // Engine releases only a frame that is held here
   assert property (@(posedge CLK) disable iff (!RESETn) cmd_take |-> cmd_valid)
      else $error("cmd_take without a held frame");

endmodule

/* design/master_addr_reg.sv */
////////////////////////////////////////////////////////////
// Master address register
// Holds the last master address, loaded from a command or
// stepped by the transfer size for autoincrement
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bridge_params.svh"

module master_addr_reg (
   input  logic                          CLK,
   input  logic                          RESETn,
   input  logic                          load,
   input  logic                          inc,
   input  logic [`BRIDGE_ADDR_W-1:0]     load_addr,
   input  host_proto_pkg::xfer_size_t    size,
   output logic [`BRIDGE_ADDR_W-1:0]     addr
);
   import host_proto_pkg::*;

   logic [`BRIDGE_ADDR_W-1:0] step;

   assign step = `BRIDGE_ADDR_W'(xfer_bytes(size));

   always_ff @(posedge CLK)
   begin
      if (!RESETn)
         addr <= '0;
      else if (load)
         addr <= load_addr;
      else if (inc)
         // Steps even after an error response
         addr <= addr + step;
   end

endmodule

/* design/ahb_master_engine.sv */
////////////////////////////////////////////////////////////
// AHB-Lite master engine
// Runs one single transfer per command frame and builds
// the response frame for the serializer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bridge_params.svh"

module ahb_master_engine (
   input  logic                                            CLK,
   input  logic                                            RESETn,
   input  logic                                            cmd_valid,
   input  host_proto_pkg::host_op_t                        cmd_op,
   input  host_proto_pkg::xfer_size_t                      cmd_size,
   input  logic [`BRIDGE_ADDR_W-1:0]                       cmd_addr,
   input  logic [`BRIDGE_DATA_W-1:0]                       cmd_data,
   output logic                                            cmd_take,
   output logic [`BRIDGE_ADDR_W-1:0]                       HADDR,
   output ahb_pkg::htrans_t                                HTRANS,
   output logic                                            HWRITE,
   output ahb_pkg::hsize_t                                 HSIZE,
   output logic [2:0]                                      HBURST,
   output logic [3:0]                                      HPROT,
   output logic [`BRIDGE_DATA_W-1:0]                       HWDATA,
   input  logic                                            HREADY,
   input  logic [`BRIDGE_DATA_W-1:0]                       HRDATA,
   input  logic                                            HRESP,
   output logic                                            resp_push,
   output logic [`BRIDGE_OUT_FRAME_MAX*`BRIDGE_BYTE_W-1:0] resp_bytes,
   output logic [2:0]                                      resp_len,
   input  logic                                            resp_ready
);
   import ahb_pkg::*;
   import host_proto_pkg::*;

   localparam int DATA_BYTES = `BRIDGE_DATA_W / `BRIDGE_BYTE_W;

   typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_RESP} state_t;

   state_t                    state;
   logic                      write_q;
   xfer_size_t                size_q;
   logic                      hresp_q;
   logic [`BRIDGE_DATA_W-1:0] wdata_q;
   logic [`BRIDGE_DATA_W-1:0] rdata_q;
   logic [2:0]                nbytes;
   logic                      addr_load;
   logic                      addr_inc;

   assign cmd_take  = (state == S_IDLE) && cmd_valid;
   assign addr_load = cmd_take && (cmd_op == MST_READ || cmd_op == MST_WRITE);
   assign addr_inc  = cmd_take && (cmd_op == MST_READ_INC || cmd_op == MST_WRITE_INC);

   // Address is ready the cycle after the take, along with NONSEQ
   master_addr_reg u_addr_reg (
      .CLK       (CLK),
      .RESETn    (RESETn),
      .load      (addr_load),
      .inc       (addr_inc),
      .load_addr (cmd_addr),
      .size      (cmd_size),
      .addr      (HADDR)
   );

   // Only the address phase carries NONSEQ, so one transfer per command
   assign HTRANS = (state == S_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign HWRITE = write_q;
   assign HSIZE  = hsize_t'({1'b0, size_q});
   assign HBURST = HBURST_SINGLE;
   assign HPROT  = `BRIDGE_HPROT;
   assign HWDATA = wdata_q << {HADDR[1:0], 3'b000};

   always_ff @(posedge CLK)
   begin
      if (!RESETn)
      begin
         state   <= S_IDLE;
         write_q <= 1'b0;
         size_q  <= XFER_BYTE;
      end
      else
      begin
         case (state)
            S_IDLE:
               if (cmd_valid)
               begin
                  write_q <= (cmd_op == MST_WRITE) || (cmd_op == MST_WRITE_INC);
                  size_q  <= cmd_size;
                  state   <= S_ADDR;
               end
            S_ADDR:
               if (HREADY)
                  state <= S_DATA;
            S_DATA:
               if (HREADY)
                  state <= S_RESP;
            default:
               // Wait here while both output buffers are full
               if (resp_ready)
                  state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK)
   begin
      if (cmd_take)
         wdata_q <= cmd_data;
      if (state == S_DATA && HREADY)
      begin
         rdata_q <= HRDATA >> {HADDR[1:0], 3'b000};
         hresp_q <= HRESP;
      end
   end

   assign resp_push = (state == S_RESP) && resp_ready;
   assign nbytes    = xfer_bytes(size_q);

   // Header in the low byte, then read data most significant first
   always_comb
   begin
      resp_bytes      = '0;
      resp_bytes[7:0] = {RESP_TAG, hresp_q, write_q ? RESP_WR_FIELD : size_q};
      if (!write_q)
      begin
         for (int i = 0; i < DATA_BYTES; i++)
         begin
            if (i < nbytes)
               resp_bytes[8*(i+1) +: 8] = rdata_q[8*(nbytes-1-i) +: 8];
         end
      end
      resp_len = write_q ? 3'd1 : 3'd1 + nbytes;
   end

   // Size 3 frames are dropped by the parser
   assert property (@(posedge CLK) disable iff (!RESETn)
                    (HTRANS != HTRANS_IDLE) |-> (HSIZE <= HSIZE_WORD))
      else $error("HSIZE above word on a live transfer");

endmodule

/* design/host_resp_serializer.sv */
////////////////////////////////////////////////////////////
// Response serializer
// Two output buffers, one filling while the other shifts
// bytes out to the write FIFO, low byte first
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bridge_params.svh"

module host_resp_serializer (
   input  logic                                            CLK,
   input  logic                                            RESETn,
   input  logic                                            resp_push,
   input  logic [`BRIDGE_OUT_FRAME_MAX*`BRIDGE_BYTE_W-1:0] resp_bytes,
   input  logic [2:0]                                      resp_len,
   output logic                                            resp_ready,
   input  logic                                            fifo_wrfull,
   output logic                                            fifo_wren,
   output logic [`BRIDGE_BYTE_W-1:0]                       fifo_wrdata
);
   localparam int FRAME_W = `BRIDGE_OUT_FRAME_MAX * `BRIDGE_BYTE_W;

   logic [1:0][FRAME_W-1:0] obuf;
   logic [1:0][2:0]         ocnt;
   logic                    in_idx;
   logic                    out_idx;

   // Filling side must be empty before it takes a frame
   assign resp_ready  = (ocnt[in_idx] == 3'd0);
   assign fifo_wren   = (ocnt[out_idx] != 3'd0) && !fifo_wrfull;
   assign fifo_wrdata = obuf[out_idx][`BRIDGE_BYTE_W-1:0];

   always_ff @(posedge CLK)
   begin
      if (!RESETn)
      begin
         ocnt    <= '0;
         in_idx  <= 1'b0;
         out_idx <= 1'b0;
      end
      else
      begin
         if (resp_push)
         begin
            ocnt[in_idx] <= resp_len;
            in_idx       <= !in_idx;
         end
         if (fifo_wren)
         begin
            ocnt[out_idx] <= ocnt[out_idx] - 3'd1;
            // Last byte hands the FIFO side to the other buffer
            if (ocnt[out_idx] == 3'd1)
               out_idx <= !out_idx;
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (resp_push)
         obuf[in_idx] <= resp_bytes;
      if (fifo_wren)
         obuf[out_idx] <= obuf[out_idx] >> `BRIDGE_BYTE_W;
   end

   // Engine holds a finished response until a buffer frees up
   assert property (@(posedge CLK) disable iff (!RESETn) resp_push |-> resp_ready)
      else $error("Response pushed with both buffers full");

endmodule

/* design/ahb_host_bridge_top.sv */
////////////////////////////////////////////////////////////
// AHB host bridge
// Host byte FIFOs in, AHB-Lite master out. Parser, master
// engine and response serializer in a chain
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bridge_params.svh"

module ahb_host_bridge_top (
   input  logic                          CLK,
   input  logic                          RESETn,
   output logic [`BRIDGE_ADDR_W-1:0]     mst_HADDR,
   output ahb_pkg::htrans_t              mst_HTRANS,
   output logic                          mst_HWRITE,
   output ahb_pkg::hsize_t               mst_HSIZE,
   output logic [2:0]                    mst_HBURST,
   output logic [3:0]                    mst_HPROT,
   output logic [`BRIDGE_DATA_W-1:0]     mst_HWDATA,
   input  logic                          mst_HREADY,
   input  logic [`BRIDGE_DATA_W-1:0]     mst_HRDATA,
   input  logic                          mst_HRESP,
   output logic                          fifo_rden,
   input  logic                          fifo_rdempty,
   input  logic [`BRIDGE_BYTE_W-1:0]     fifo_rddata,
   output logic                          fifo_wren,
   input  logic                          fifo_wrfull,
   output logic [`BRIDGE_BYTE_W-1:0]     fifo_wrdata
);
   import host_proto_pkg::*;

   // Parser to engine
   logic                                            cmd_valid;
   host_op_t                                        cmd_op;
   xfer_size_t                                      cmd_size;
   logic [`BRIDGE_ADDR_W-1:0]                       cmd_addr;
   logic [`BRIDGE_DATA_W-1:0]                       cmd_data;
   logic                                            cmd_take;

   // Engine to serializer
   logic                                            resp_push;
   logic [`BRIDGE_OUT_FRAME_MAX*`BRIDGE_BYTE_W-1:0] resp_bytes;
   logic [2:0]                                      resp_len;
   logic                                            resp_ready;

   host_cmd_parser u_parser (
      .CLK          (CLK),
      .RESETn       (RESETn),
      .fifo_rdempty (fifo_rdempty),
      .fifo_rddata  (fifo_rddata),
      .fifo_rden    (fifo_rden),
      .cmd_valid    (cmd_valid),
      .cmd_op       (cmd_op),
      .cmd_size     (cmd_size),
      .cmd_addr     (cmd_addr),
      .cmd_data     (cmd_data),
      .cmd_take     (cmd_take)
   );

   ahb_master_engine u_engine (
      .CLK        (CLK),
      .RESETn     (RESETn),
      .cmd_valid  (cmd_valid),
      .cmd_op     (cmd_op),
      .cmd_size   (cmd_size),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .cmd_take   (cmd_take),
      .HADDR      (mst_HADDR),
      .HTRANS     (mst_HTRANS),
      .HWRITE     (mst_HWRITE),
      .HSIZE      (mst_HSIZE),
      .HBURST     (mst_HBURST),
      .HPROT      (mst_HPROT),
      .HWDATA     (mst_HWDATA),
      .HREADY     (mst_HREADY),
      .HRDATA     (mst_HRDATA),
      .HRESP      (mst_HRESP),
      .resp_push  (resp_push),
      .resp_bytes (resp_bytes),
      .resp_len   (resp_len),
      .resp_ready (resp_ready)
   );

   host_resp_serializer u_serializer (
      .CLK         (CLK),
      .RESETn      (RESETn),
      .resp_push   (resp_push),
      .resp_bytes  (resp_bytes),
      .resp_len    (resp_len),
      .resp_ready  (resp_ready),
      .fifo_wrfull (fifo_wrfull),
      .fifo_wren   (fifo_wren),
      .fifo_wrdata (fifo_wrdata)
   );

endmodule

/* sim/ahb_mem_model.sv */
////////////////////////////////////////////////////////////
// AHB-Lite slave memory
// 256 words with random wait states; addresses with bit 12
// set fall in the error window and answer with HRESP high
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ahb_mem_model (
   input  logic                 CLK,
   input  logic                 RESETn,
   input  logic [31:0]          HADDR,
   input  ahb_pkg::htrans_t     HTRANS,
   input  logic                 HWRITE,
   input  ahb_pkg::hsize_t      HSIZE,
   input  logic [31:0]          HWDATA,
   output logic                 HREADY,
   output logic [31:0]          HRDATA,
   output logic                 HRESP
);
   import ahb_pkg::*;

   logic [31:0] mem [256];
   logic        dp;
   logic        dp_write;
   logic        dp_err;
   logic [31:0] dp_addr;
   logic [2:0]  dp_size;
   int unsigned waits;

   // Distinct power-up value in every word
   initial
   begin
      dp = 1'b0;
      for (int i = 0; i < 256; i++)
         mem[i] = (32'h9E3779B9 * (i + 1)) ^ {i[7:0], 24'h0};
   end

   assign HREADY = !dp || (waits == 0);
   assign HRESP  = dp && dp_err;
   assign HRDATA = (dp && !dp_err) ? mem[dp_addr[9:2]] : 32'h0;

   always @(posedge CLK)
   begin
      if (!RESETn)
      begin
         dp    <= 1'b0;
         waits <= 0;
      end
      else if (dp && waits != 0)
         waits <= waits - 1;
      else
      begin
         // Write the lanes covered by the size as the data phase completes
         if (dp && dp_write && !dp_err)
         begin
            for (int b = 0; b < 4; b++)
               if (b >= dp_addr[1:0] && b < dp_addr[1:0] + (1 << dp_size))
                  mem[dp_addr[9:2]][8*b +: 8] <= HWDATA[8*b +: 8];
         end
         dp <= (HTRANS == HTRANS_NONSEQ);
         if (HTRANS == HTRANS_NONSEQ)
         begin
            dp_addr  <= HADDR;
            dp_write <= HWRITE;
            dp_size  <= HSIZE;
            dp_err   <= HADDR[12];
            waits    <= $urandom % 3;
         end
      end
   end

endmodule

/* sim/tb_ahb_host_bridge.sv */
////////////////////////////////////////////////////////////
// AHB host bridge testbench
// Host FIFO models, AHB memory, reference model and
// assertions on the response byte stream
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ahb_host_bridge;
   import ahb_pkg::*;
   import host_proto_pkg::*;

   logic             CLK;
   logic             RESETn;
   logic [31:0]      HADDR;
   htrans_t          HTRANS;
   logic             HWRITE;
   hsize_t           HSIZE;
   logic [2:0]       HBURST;
   logic [3:0]       HPROT;
   logic [31:0]      HWDATA;
   logic             HREADY;
   logic [31:0]      HRDATA;
   logic             HRESP;
   logic             fifo_rden;
   logic             fifo_rdempty;
   logic [7:0]       fifo_rddata;
   logic             fifo_wren;
   logic             fifo_wrfull;
   logic [7:0]       fifo_wrdata;

   logic [7:0]  rd_q [$];
   logic [7:0]  exp_q [$];
   logic [7:0]  exp_head;
   int          exp_cnt;
   logic [31:0] ref_mem [256];
   logic [31:0] ref_addr;
   int          frames;
   int          exp_xfers;
   int          xfer_seen;
   int          val_errs;
   int          other_errs;
   logic        stim_done;
   logic        rden_q;
   logic        wren_q;

   ahb_host_bridge_top u_dut (
      .CLK (CLK), .RESETn (RESETn),
      .mst_HADDR (HADDR), .mst_HTRANS (HTRANS), .mst_HWRITE (HWRITE),
      .mst_HSIZE (HSIZE), .mst_HBURST (HBURST), .mst_HPROT (HPROT),
      .mst_HWDATA (HWDATA), .mst_HREADY (HREADY), .mst_HRDATA (HRDATA),
      .mst_HRESP (HRESP),
      .fifo_rden (fifo_rden), .fifo_rdempty (fifo_rdempty), .fifo_rddata (fifo_rddata),
      .fifo_wren (fifo_wren), .fifo_wrfull (fifo_wrfull), .fifo_wrdata (fifo_wrdata)
   );

   ahb_mem_model u_mem (
      .CLK (CLK), .RESETn (RESETn), .HADDR (HADDR), .HTRANS (HTRANS),
      .HWRITE (HWRITE), .HSIZE (HSIZE), .HWDATA (HWDATA),
      .HREADY (HREADY), .HRDATA (HRDATA), .HRESP (HRESP)
   );

   always #50 CLK = !CLK;

   // Strobes sampled mid-cycle where they are stable
   always @(negedge CLK)
   begin
      rden_q = fifo_rden;
      wren_q = fifo_wren;
      if (RESETn && HTRANS == HTRANS_NONSEQ && HREADY)
         xfer_seen++;
   end

   // Read FIFO with one cycle latency and write FIFO with random stalls
   always @(posedge CLK)
   begin
      logic [7:0] b;
      logic       pop;
      pop = rden_q;
      if (pop)
         b = rd_q.pop_front();
      if (RESETn && wren_q && exp_q.size() != 0)
         void'(exp_q.pop_front());
      exp_cnt  = exp_q.size();
      exp_head = (exp_cnt != 0) ? exp_q[0] : 8'h00;
      #1;
      if (pop)
         fifo_rddata = b;
      fifo_rdempty = (rd_q.size() == 0);
      fifo_wrfull  = ($urandom % 4 == 0);
   end

   assert property (@(posedge CLK) disable iff (!RESETn)
                    fifo_wren |-> (exp_cnt != 0 && fifo_wrdata == exp_head))
   else
   begin
      if (exp_cnt == 0)
      begin
         other_errs++;
         $display("Byte written to the FIFO with no response expected");
      end
      else
      begin
         val_errs++;
         $display("ERR fifo_wrdata got %h exp %h", fifo_wrdata, exp_head);
      end
   end

   assert property (@(posedge CLK) $rose(RESETn) |-> (HTRANS == HTRANS_IDLE && !fifo_wren))
   else
   begin
      other_errs++;
      $display("Bus or write FIFO active right after reset");
   end

   assert property (@(posedge CLK) disable iff (!RESETn) fifo_rdempty |-> !fifo_rden)
   else
   begin
      other_errs++;
      $display("Read FIFO strobed while empty");
   end

   assert property (@(posedge CLK) disable iff (!RESETn)
                    (HTRANS == HTRANS_NONSEQ) |-> (HBURST == 3'd0 && HPROT == 4'b0011))
   else
   begin
      val_errs++;
      $display("ERR HBURST/HPROT got %h/%h exp 0/3", HBURST, HPROT);
   end

   function automatic logic [31:0] fill_word(int i);
      return (32'h9E3779B9 * (i + 1)) ^ {i[7:0], 24'h0};
   endfunction

   // Queue one frame and the response it must produce
   task automatic send_cmd(input logic [4:0] op, input logic [1:0] sz,
                           input logic [31:0] addr, input logic [31:0] data);
      int          n;
      int          lane;
      logic        err;
      logic        wr;
      logic [31:0] word;
      n  = 1 << sz;
      wr = (op == MST_WRITE || op == MST_WRITE_INC);
      rd_q.push_back({op, 1'b0, sz});
      if (wr)
         for (int i = n - 1; i >= 0; i--)
            rd_q.push_back(data[8*i +: 8]);
      if (op == MST_READ || op == MST_WRITE)
      begin
         for (int i = 3; i >= 0; i--)
            rd_q.push_back(addr[8*i +: 8]);
         ref_addr = addr;
      end
      else
         ref_addr = ref_addr + n;
      err = ref_addr[12];
      if (wr)
      begin
         exp_q.push_back({RESP_TAG, err, 2'b11});
         for (int i = 0; i < n && !err; i++)
         begin
            lane = ref_addr[1:0] + i;
            ref_mem[ref_addr[9:2]][8*lane +: 8] = data[8*i +: 8];
         end
      end
      else
      begin
         exp_q.push_back({RESP_TAG, err, sz});
         word = err ? 32'h0 : ref_mem[ref_addr[9:2]] >> (8 * ref_addr[1:0]);
         for (int i = n - 1; i >= 0; i--)
            exp_q.push_back(word[8*i +: 8]);
      end
      exp_cnt  = exp_q.size();
      exp_head = exp_q[0];
      frames++;
      exp_xfers++;
   endtask

   // Lone reserved code or size 3 byte that must vanish
   task automatic push_ignored_byte(input logic [7:0] b);
      rd_q.push_back(b);
      frames++;
   endtask

   function automatic logic [31:0] aligned_addr(int base, logic [1:0] sz);
      return base + (($urandom % 4) & ~((1 << sz) - 1));
   endfunction

   initial
   begin
      logic [1:0] sz;
      void'($urandom(22288));
      CLK          = 0;
      RESETn       = 0;
      fifo_rdempty = 1;
      fifo_rddata  = 0;
      fifo_wrfull  = 0;
      rden_q       = 0;
      wren_q       = 0;
      exp_cnt      = 0;
      exp_head     = 0;
      ref_addr     = 0;
      frames       = 0;
      exp_xfers    = 0;
      xfer_seen    = 0;
      val_errs     = 0;
      other_errs   = 0;
      stim_done    = 0;
      for (int i = 0; i < 256; i++)
         ref_mem[i] = fill_word(i);
      repeat (10) @(posedge CLK);
      #1 RESETn = 1;
      repeat (3) @(posedge CLK);
      // Each size at every aligned offset, then untouched words
      for (int s = 0; s < 3; s++)
         for (int off = 0; off < 4; off += (1 << s))
         begin
            send_cmd(MST_WRITE, s, 32'h100 + 4*s + off, $urandom);
            send_cmd(MST_READ, s, 32'h100 + 4*s + off, 0);
            send_cmd(MST_READ, s, 32'h200 + 4*s + off, 0);
         end
      push_ignored_byte(8'h00);
      send_cmd(MST_WRITE, 2, 32'h300, $urandom);
      for (int i = 0; i < 3; i++)
         send_cmd(MST_WRITE_INC, 2, 0, $urandom);
      push_ignored_byte(8'h2B);
      send_cmd(MST_READ, 2, 32'h2FC, 0);
      for (int i = 0; i < 4; i++)
         send_cmd(MST_READ_INC, 2, 0, 0);
      send_cmd(MST_WRITE, 1, 32'h340, $urandom);
      send_cmd(MST_WRITE_INC, 1, 0, $urandom);
      send_cmd(MST_READ, 1, 32'h340, 0);
      send_cmd(MST_READ_INC, 1, 0, 0);
      push_ignored_byte(8'h5A);
      // Error window
      send_cmd(MST_READ, 2, 32'h1004, 0);
      send_cmd(MST_WRITE, 1, 32'h1008, $urandom);
      send_cmd(MST_WRITE_INC, 1, 0, $urandom);
      push_ignored_byte(8'hF1);
      for (int i = 0; i < 40; i++)
      begin
         sz = $urandom % 3;
         if (i % 9 == 4)
            push_ignored_byte(8'h23);
         if ($urandom % 2)
            send_cmd(MST_WRITE, sz, aligned_addr(4 * ($urandom % 256), sz), $urandom);
         else
            send_cmd(MST_READ, sz, aligned_addr(4 * ($urandom % 256), sz), 0);
      end
      stim_done = 1;
      wait (rd_q.size() == 0 && exp_cnt == 0);
      repeat (20) @(posedge CLK);
      if (xfer_seen != exp_xfers)
      begin
         other_errs++;
         $display("AHB transfer count is %0d, %0d expected", xfer_seen, exp_xfers);
      end
      $display("Errors: %0d value, %0d other", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      wait (stim_done);
      repeat (200 * frames + 1000) @(posedge CLK);
      $display("Timeout with %0d response bytes still outstanding", exp_cnt);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* build.f */
+incdir+design
design/ahb_pkg.sv
design/host_proto_pkg.sv
design/host_cmd_parser.sv
design/master_addr_reg.sv
design/ahb_master_engine.sv
design/host_resp_serializer.sv
design/ahb_host_bridge_top.sv
sim/ahb_mem_model.sv
sim/tb_ahb_host_bridge.sv

/* Bender.yml */
package:
  name: ahb_host_bridge

sources:
  - include_dirs:
      - design
    files:
      - design/ahb_pkg.sv
      - design/host_proto_pkg.sv
      - design/host_cmd_parser.sv
      - design/master_addr_reg.sv
      - design/ahb_master_engine.sv
      - design/host_resp_serializer.sv
      - design/ahb_host_bridge_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/ahb_mem_model.sv
      - sim/tb_ahb_host_bridge.sv
